// File: radio_core_pkg.sv
package radio_core_pkg;

   // ------------------------------
   // widths
   // ------------------------------
   localparam int COMP_W   = 16;            // one I or Q component
   localparam int SAMPLE_W = 2 * COMP_W;    // I upper half, Q lower half
   localparam int WORD_W   = 32;            // settings, gpio and misc words
   localparam int ADDR_W   = 8;             // settings and readback address
   localparam int LED_W    = 3;
   localparam int NUM_ATR  = 4;             // one gpio word per atr state

   typedef logic        [SAMPLE_W-1:0] sample_t;
   typedef logic signed [COMP_W-1:0]   comp_t;
   typedef logic        [WORD_W-1:0]   word_t;
   typedef logic        [ADDR_W-1:0]   sr_addr_t;
   typedef logic        [LED_W-1:0]    led_t;      // {rx, txrx_tx, txrx_rx}

   // atr state, encoded as {run_tx, run_rx}
   typedef enum logic [1:0] {
      ATR_IDLE = 2'b00,
      ATR_RX   = 2'b01,
      ATR_TX   = 2'b10,
      ATR_FDX  = 2'b11
   } atr_state_t;

   // limits of one signed component
   localparam comp_t COMP_MAX = comp_t'(16'h7FFF);
   localparam comp_t COMP_MIN = comp_t'(16'h8000);

   // ------------------------------
   // settings register map
   // ------------------------------
   localparam sr_addr_t SR_DB_BASE = 8'd160;

   // four gpio words from here on, in atr order idle, rx, tx, fdx
   localparam sr_addr_t SR_DB_GPIO = SR_DB_BASE;
   localparam sr_addr_t SR_DB_DDR  = SR_DB_BASE + 8'd4;    // gpio direction
   localparam sr_addr_t SR_DB_MISC = SR_DB_BASE + 8'd5;    // misc output word

   // dc offsets, I in the upper 16 bits and Q in the lower
   localparam sr_addr_t SR_TX_FE_BASE = SR_DB_BASE + 8'd48;
   localparam sr_addr_t SR_RX_FE_BASE = SR_DB_BASE + 8'd64;

   // baseband pattern step, I increment in the upper 16 bits
   localparam sr_addr_t SR_BB_BASE = 8'd240;

   // ------------------------------
   // readback map
   // ------------------------------
   localparam sr_addr_t RB_DB_BASE   = 8'd16;
   localparam sr_addr_t RB_GPIO_IN   = RB_DB_BASE;           // raw db gpio pins
   localparam sr_addr_t RB_MISC_IN   = RB_DB_BASE + 8'd1;    // registered misc in
   localparam sr_addr_t RB_GPIO_OUT  = RB_DB_BASE + 8'd2;    // gpio word now driven
   localparam sr_addr_t RB_RX_OFFSET = RB_DB_BASE + 8'd3;    // rx dc offset word
   // everything else reads back as zero

endpackage

// File: settings_if.sv
`timescale 1ns/1ps

interface settings_if;
   import radio_core_pkg::*;

   logic     set_stb;     // one cycle write strobe
   sr_addr_t set_addr;    // target register of the write
   word_t    set_data;    // loaded on the strobe edge
   sr_addr_t rb_addr;     // readback select, taken with i_rb_stb

   // top level drives the bus from its ports
   modport host (
      output set_stb, set_addr, set_data, rb_addr
   );

   // register blocks decode and never drive
   modport regs (
      input set_stb, set_addr, set_data, rb_addr
   );

endinterface

// File: sample_if.sv
`timescale 1ns/1ps

interface sample_if;
   import radio_core_pkg::*;

   logic    rx_stb;       // rx_data valid this cycle
   sample_t rx_data;      // {I, Q}
   logic    tx_stb;       // tx_data valid this cycle
   sample_t tx_data;      // {I, Q}

   // baseband source side, already muxed and registered
   modport src (
      output rx_stb, rx_data, tx_stb, tx_data
   );

   // front end correction side
   modport dst (
      input rx_stb, rx_data, tx_stb, tx_data
   );

endinterface

// File: db_gpio_ctrl.sv
`timescale 1ns/1ps

module db_gpio_ctrl (
   input  logic                  radio_clk,
   input  logic                  i_arst_n,
   settings_if.regs              bus,
   input  logic                  i_rb_stb,
   input  logic                  i_rx_running,
   input  logic                  i_tx_running,
   input  radio_core_pkg::word_t i_db_gpio_in,
   input  radio_core_pkg::word_t i_misc_in,
   output radio_core_pkg::word_t o_rb_data,
   output radio_core_pkg::word_t o_db_gpio_out,
   output radio_core_pkg::word_t o_db_gpio_ddr,
   output radio_core_pkg::word_t o_misc_out,
   output radio_core_pkg::led_t  o_radio_led
);
   import radio_core_pkg::*;

   word_t      gpio_atr [NUM_ATR];   // output word per atr state
   word_t      gpio_ddr;             // direction, 1 = output
   word_t      misc_out;             // misc out before the output flop
   word_t      misc_in_q;            // misc in, registered once
   word_t      rx_offset;            // copy of the fe rx offset for readback
   atr_state_t atr;
   word_t      rb_mux;

   // ------------------------------
   // settings registers
   // ------------------------------
   always_ff @(posedge radio_clk or negedge i_arst_n)
   begin
      if (!i_arst_n)
      begin
         for (int k = 0; k < NUM_ATR; k++)
         begin
            gpio_atr[k] <= '0;
         end
         gpio_ddr  <= '0;
         misc_out  <= '0;
         rx_offset <= '0;
      end
      else if (bus.set_stb)
      begin
         for (int k = 0; k < NUM_ATR; k++)
         begin
            if (bus.set_addr == SR_DB_GPIO + sr_addr_t'(k))
            begin
               gpio_atr[k] <= bus.set_data;
            end
         end
         if (bus.set_addr == SR_DB_DDR)
         begin
            gpio_ddr <= bus.set_data;
         end
         if (bus.set_addr == SR_DB_MISC)
         begin
            misc_out <= bus.set_data;
         end
         // the same write also lands in fe_correction
         if (bus.set_addr == SR_RX_FE_BASE)
         begin
            rx_offset <= bus.set_data;
         end
      end
   end

   // ------------------------------
   // atr driven outputs
   // ------------------------------
   assign atr = atr_state_t'({i_tx_running, i_rx_running});

   always_ff @(posedge radio_clk or negedge i_arst_n)
   begin
      if (!i_arst_n)
      begin
         o_db_gpio_out <= '0;
         o_db_gpio_ddr <= '0;
         o_radio_led   <= '0;
         o_misc_out    <= '0;
         misc_in_q     <= '0;
      end
      else
      begin
         case (atr)
            ATR_IDLE: o_db_gpio_out <= gpio_atr[0];
            ATR_RX:   o_db_gpio_out <= gpio_atr[1];
            ATR_TX:   o_db_gpio_out <= gpio_atr[2];
            ATR_FDX:  o_db_gpio_out <= gpio_atr[3];
            default:  o_db_gpio_out <= gpio_atr[0];
         endcase
         o_db_gpio_ddr <= gpio_ddr;
         // rx, txrx_tx, then txrx_rx only when not transmitting
         o_radio_led   <= {i_rx_running, i_tx_running, i_rx_running & ~i_tx_running};
         o_misc_out    <= misc_out;     // second stage toward the pins
         misc_in_q     <= i_misc_in;
      end
   end

   // ------------------------------
   // readback
   // ------------------------------
   always_comb
   begin
      case (bus.rb_addr)
         RB_GPIO_IN:   rb_mux = i_db_gpio_in;
         RB_MISC_IN:   rb_mux = misc_in_q;
         RB_GPIO_OUT:  rb_mux = o_db_gpio_out;
         RB_RX_OFFSET: rb_mux = rx_offset;
         default:      rb_mux = '0;      // unmapped
      endcase
   end

   // loaded only on the strobe, holds between reads
   always_ff @(posedge radio_clk or negedge i_arst_n)
   begin
      if (!i_arst_n)
      begin
         o_rb_data <= '0;
      end
      else if (i_rb_stb)
      begin
         o_rb_data <= rb_mux;
      end
   end

endmodule

// File: bb_sample_source.sv
`timescale 1ns/1ps

module bb_sample_source (
   input  logic                    radio_clk,
   input  logic                    i_arst_n,
   settings_if.regs                bus,
   input  logic                    i_rx_running,
   input  logic                    i_tx_running,
   input  logic                    i_rx_stb,
   input  radio_core_pkg::sample_t i_adc_rx,
   input  logic                    i_tx_stb,
   input  radio_core_pkg::sample_t i_host_tx,
   sample_if.src                   samples
);
   import radio_core_pkg::*;

   comp_t   step;       // I increment, upper half of the step word
   comp_t   acc;        // I ramp, counts rx strobes while running
   sample_t pattern;

   // current ramp value as I, its inverse as Q
   assign pattern = {acc, ~acc};

   always_ff @(posedge radio_clk or negedge i_arst_n)
   begin
      if (!i_arst_n)
      begin
         step <= '0;
      end
      else if (bus.set_stb && (bus.set_addr == SR_BB_BASE))
      begin
         step <= comp_t'(bus.set_data[WORD_W-1 -: COMP_W]);
      end
   end

   // ------------------------------
   // ramp accumulator
   // ------------------------------
   always_ff @(posedge radio_clk or negedge i_arst_n)
   begin
      if (!i_arst_n)
      begin
         acc <= '0;
      end
      else if (!i_rx_running)
      begin
         acc <= '0;                 // restart from zero
      end
      else if (i_rx_stb)
      begin
         acc <= acc + step;         // sample saw the old value
      end
   end

   // substitute the pattern per direction, one register stage
   always_ff @(posedge radio_clk or negedge i_arst_n)
   begin
      if (!i_arst_n)
      begin
         samples.rx_stb  <= 1'b0;
         samples.rx_data <= '0;
         samples.tx_stb  <= 1'b0;
         samples.tx_data <= '0;
      end
      else
      begin
         samples.rx_stb  <= i_rx_stb;
         samples.rx_data <= i_rx_running ? pattern : i_adc_rx;
         samples.tx_stb  <= i_tx_stb;
         samples.tx_data <= i_tx_running ? pattern : i_host_tx;
      end
   end

endmodule

// File: fe_correction.sv
`timescale 1ns/1ps

module fe_correction (
   input  logic                    radio_clk,
   input  logic                    i_arst_n,
   settings_if.regs                bus,
   sample_if.dst                   samples,
   output logic                    o_rx_stb,
   output radio_core_pkg::sample_t o_host_rx,
   output logic                    o_tx_stb,
   output radio_core_pkg::sample_t o_dac_tx
);
   import radio_core_pkg::*;

   word_t   rx_off;     // {I offset, Q offset}
   word_t   tx_off;
   sample_t rx_corr;
   sample_t tx_corr;

   // ------------------------------
   // saturating arithmetic
   // ------------------------------
   function automatic comp_t sat_sum(input comp_t a, input comp_t b, input logic sub);
      logic signed [COMP_W:0] full;   // one guard bit is enough for a single add
      if (sub)
      begin
         full = a - b;
      end
      else
      begin
         full = a + b;
      end
      if (full > COMP_MAX)
      begin
         return COMP_MAX;
      end
      else if (full < COMP_MIN)
      begin
         return COMP_MIN;
      end
      return comp_t'(full);
   endfunction

   // apply an offset word to both halves of a sample
   function automatic sample_t correct(input sample_t s, input word_t off, input logic sub);
      comp_t i_part;
      comp_t q_part;
      i_part = sat_sum(comp_t'(s[SAMPLE_W-1 -: COMP_W]), comp_t'(off[WORD_W-1 -: COMP_W]), sub);
      q_part = sat_sum(comp_t'(s[COMP_W-1:0]), comp_t'(off[COMP_W-1:0]), sub);
      return {i_part, q_part};
   endfunction

   // ------------------------------
   // offset registers
   // ------------------------------
   always_ff @(posedge radio_clk or negedge i_arst_n)
   begin
      if (!i_arst_n)
      begin
         rx_off <= '0;
         tx_off <= '0;
      end
      else if (bus.set_stb)
      begin
         if (bus.set_addr == SR_RX_FE_BASE) rx_off <= bus.set_data;
         if (bus.set_addr == SR_TX_FE_BASE) tx_off <= bus.set_data;
      end
   end

   assign rx_corr = correct(samples.rx_data, rx_off, 1'b1);   // rx removes the offset
   assign tx_corr = correct(samples.tx_data, tx_off, 1'b0);   // tx adds it

   // one output stage, data held between strobes
   always_ff @(posedge radio_clk or negedge i_arst_n)
   begin
      if (!i_arst_n)
      begin
         o_rx_stb  <= 1'b0;
         o_host_rx <= '0;
         o_tx_stb  <= 1'b0;
         o_dac_tx  <= '0;
      end
      else
      begin
         o_rx_stb <= samples.rx_stb;
         o_tx_stb <= samples.tx_stb;
         if (samples.rx_stb) o_host_rx <= rx_corr;
         if (samples.tx_stb) o_dac_tx  <= tx_corr;
      end
   end

endmodule

// File: radio_core_top.sv
`timescale 1ns/1ps

module radio_core_top (
   input  logic                       radio_clk,
   input  logic                       i_arst_n,
   // settings and readback from the host
   input  logic                       i_set_stb,
   input  radio_core_pkg::sr_addr_t   i_set_addr,
   input  radio_core_pkg::word_t      i_set_data,
   input  logic                       i_rb_stb,
   input  radio_core_pkg::sr_addr_t   i_rb_addr,
   output radio_core_pkg::word_t      o_rb_data,
   // atr levels
   input  logic                       i_rx_running,
   input  logic                       i_tx_running,
   // sample streams
   input  logic                       i_rx_stb,
   input  radio_core_pkg::sample_t    i_adc_rx,
   input  logic                       i_tx_stb,
   input  radio_core_pkg::sample_t    i_host_tx,
   output logic                       o_rx_stb,
   output radio_core_pkg::sample_t    o_host_rx,
   output logic                       o_tx_stb,
   output radio_core_pkg::sample_t    o_dac_tx,
   // daughterboard pins and misc words
   input  radio_core_pkg::word_t      i_db_gpio_in,
   input  radio_core_pkg::word_t      i_misc_in,
   output radio_core_pkg::word_t      o_db_gpio_out,
   output radio_core_pkg::word_t      o_db_gpio_ddr,
   output radio_core_pkg::word_t      o_misc_out,
   output radio_core_pkg::led_t       o_radio_led
);

   settings_if set_bus ();   // shared by all three register blocks
   sample_if   smp ();       // bb source to front end

   // ------------------------------
   // host settings bus
   // ------------------------------
   assign set_bus.set_stb  = i_set_stb;
   assign set_bus.set_addr = i_set_addr;
   assign set_bus.set_data = i_set_data;
   assign set_bus.rb_addr  = i_rb_addr;

   // ------------------------------
   // slot blocks
   // ------------------------------
   db_gpio_ctrl u_db_gpio_ctrl (
      .radio_clk     (radio_clk),
      .i_arst_n      (i_arst_n),
      .bus           (set_bus.regs),
      .i_rb_stb      (i_rb_stb),
      .i_rx_running  (i_rx_running),
      .i_tx_running  (i_tx_running),
      .i_db_gpio_in  (i_db_gpio_in),
      .i_misc_in     (i_misc_in),
      .o_rb_data     (o_rb_data),
      .o_db_gpio_out (o_db_gpio_out),
      .o_db_gpio_ddr (o_db_gpio_ddr),
      .o_misc_out    (o_misc_out),
      .o_radio_led   (o_radio_led)
   );

   // pattern substitution comes first, correction after
   bb_sample_source u_bb_sample_source (
      .radio_clk    (radio_clk),
      .i_arst_n     (i_arst_n),
      .bus          (set_bus.regs),
      .i_rx_running (i_rx_running),
      .i_tx_running (i_tx_running),
      .i_rx_stb     (i_rx_stb),
      .i_adc_rx     (i_adc_rx),
      .i_tx_stb     (i_tx_stb),
      .i_host_tx    (i_host_tx),
      .samples      (smp.src)
   );

   fe_correction u_fe_correction (
      .radio_clk (radio_clk),
      .i_arst_n  (i_arst_n),
      .bus       (set_bus.regs),
      .samples   (smp.dst),
      .o_rx_stb  (o_rx_stb),
      .o_host_rx (o_host_rx),
      .o_tx_stb  (o_tx_stb),
      .o_dac_tx  (o_dac_tx)
   );

endmodule

// File: tb_radio_core.sv
`timescale 1ns/1ps

module tb_radio_core;
   import radio_core_pkg::*;

   // ------------------------------
   // table and run lengths
   // ------------------------------
   localparam int        NUM_ROWS    = 16;
   localparam int        ROW_CYCLES  = 3;     // drive, release, settle
   localparam int        STREAM_LEN  = 40;    // cycles per sample burst
   localparam int        NUM_STREAMS = 4;     // idle, both running, rx only, tx only
   localparam int        TIMEOUT     =
      2 * (NUM_ROWS * ROW_CYCLES + NUM_STREAMS * STREAM_LEN + 20) + 200;
   localparam time       OUT_DELAY   = 25;    // two edges, then half a period to the negedge
   localparam word_t     GPIO_IN     = 32'h1234_5678;
   localparam word_t     MISC_IN     = 32'h5A5A_0F0F;
   localparam logic [15:0] BB_INC    = 16'h1234;   // matches the step row
   localparam word_t     RX_OFF      = 32'h4000_C000;
   localparam word_t     TX_OFF      = 32'h2000_E000;

   typedef struct {
      logic     set_stb;
      sr_addr_t set_addr;
      word_t    set_data;
      logic     rx_run;
      logic     tx_run;
      logic     rb_stb;
      sr_addr_t rb_addr;
      word_t    exp_gpio;
      word_t    exp_ddr;
      word_t    exp_misc;
      word_t    exp_rb;
      led_t     exp_led;
   } row_t;

   logic     radio_clk = 1'b0;
   logic     i_arst_n;
   logic     i_set_stb, i_rb_stb, i_rx_running, i_tx_running, i_rx_stb, i_tx_stb;
   sr_addr_t i_set_addr, i_rb_addr;
   word_t    i_set_data, i_db_gpio_in, i_misc_in;
   sample_t  i_adc_rx, i_host_tx;
   word_t    o_rb_data, o_db_gpio_out, o_db_gpio_ddr, o_misc_out;
   logic     o_rx_stb, o_tx_stb;
   sample_t  o_host_rx, o_dac_tx;
   led_t     o_radio_led;

   row_t        table_rows [NUM_ROWS];
   sample_t     exp_rx_q [$];     // predicted o_host_rx, in order
   sample_t     exp_tx_q [$];     // predicted o_dac_tx
   time         exp_rx_t [$];     // when each rx sample is due
   time         exp_tx_t [$];
   logic [31:0] rnd_state = 32'ha546_9833;
   int          ctrl_errors = 0;
   int          sample_errors = 0;
   int          cycles = 0;

   always #5 radio_clk = ~radio_clk;   // 10 ns period

   radio_core_top DUT (.*);

   // ------------------------------
   // helpers
   // ------------------------------
   function automatic logic [31:0] next_rand();
      rnd_state = rnd_state ^ (rnd_state << 13);
      rnd_state = rnd_state ^ (rnd_state >> 17);
      rnd_state = rnd_state ^ (rnd_state << 5);
      return rnd_state;
   endfunction

   // clamp to the signed 16 bit range
   function automatic logic [15:0] clamp16(input int v);
      if (v > 32767) return 16'h7FFF;
      if (v < -32768) return 16'h8000;
      return v[15:0];
   endfunction

   // rx subtracts the offset per component, tx adds it
   function automatic sample_t apply_offset(input sample_t s, input word_t off, input bit sub);
      int si, sq, oi, oq;
      si = $signed(s[31:16]);
      sq = $signed(s[15:0]);
      oi = $signed(off[31:16]);
      oq = $signed(off[15:0]);
      if (sub) return {clamp16(si - oi), clamp16(sq - oq)};
      return {clamp16(si + oi), clamp16(sq + oq)};
   endfunction

   task automatic load_table();
      // stb  addr    data          rx tx rb rb_addr gpio        ddr         misc      rb     led
      table_rows[0]  = '{0, 8'd0,   32'h0,        0, 0, 1, 8'h40, 32'h0,      32'h0, 32'h0, 32'h0, 3'b000};
      table_rows[1]  = '{1, 8'd160, 32'h0000_1111, 0, 0, 0, 8'h0, 32'h1111, 32'h0, 32'h0, 32'h0, 3'b000};
      table_rows[2]  = '{1, 8'd161, 32'h0000_2222, 0, 0, 0, 8'h0, 32'h1111, 32'h0, 32'h0, 32'h0, 3'b000};
      table_rows[3]  = '{1, 8'd162, 32'h0000_3333, 0, 0, 0, 8'h0, 32'h1111, 32'h0, 32'h0, 32'h0, 3'b000};
      table_rows[4]  = '{1, 8'd163, 32'h0000_4444, 0, 0, 0, 8'h0, 32'h1111, 32'h0, 32'h0, 32'h0, 3'b000};
      table_rows[5]  = '{1, 8'd164, 32'hFFFF_0000, 0, 0, 0, 8'h0, 32'h1111, 32'hFFFF_0000, 32'h0,
                         32'h0, 3'b000};
      table_rows[6]  = '{1, 8'd165, 32'h0000_ABCD, 0, 0, 0, 8'h0, 32'h1111, 32'hFFFF_0000, 32'hABCD,
                         32'h0, 3'b000};
      table_rows[7]  = '{0, 8'd0, 32'h0, 1, 0, 0, 8'h0, 32'h2222, 32'hFFFF_0000, 32'hABCD, 32'h0, 3'b101};
      table_rows[8]  = '{0, 8'd0, 32'h0, 0, 1, 0, 8'h0, 32'h3333, 32'hFFFF_0000, 32'hABCD, 32'h0, 3'b010};
      table_rows[9]  = '{0, 8'd0, 32'h0, 1, 1, 0, 8'h0, 32'h4444, 32'hFFFF_0000, 32'hABCD, 32'h0, 3'b110};
      table_rows[10] = '{0, 8'd0, 32'h0, 0, 0, 1, 8'd16, 32'h1111, 32'hFFFF_0000, 32'hABCD, GPIO_IN,
                         3'b000};
      table_rows[11] = '{0, 8'd0, 32'h0, 0, 0, 1, 8'd17, 32'h1111, 32'hFFFF_0000, 32'hABCD, MISC_IN,
                         3'b000};
      table_rows[12] = '{1, 8'd224, RX_OFF, 0, 0, 1, 8'd18, 32'h1111, 32'hFFFF_0000, 32'hABCD,
                         32'h1111, 3'b000};
      table_rows[13] = '{0, 8'd0, 32'h0, 0, 0, 1, 8'd19, 32'h1111, 32'hFFFF_0000, 32'hABCD, RX_OFF,
                         3'b000};
      table_rows[14] = '{1, 8'd208, TX_OFF, 0, 0, 1, 8'd23, 32'h1111, 32'hFFFF_0000, 32'hABCD, 32'h0,
                         3'b000};
      table_rows[15] = '{1, 8'd240, {BB_INC, 16'h0}, 0, 0, 0, 8'h0, 32'h1111, 32'hFFFF_0000, 32'hABCD,
                         32'h0, 3'b000};
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      assert (got === exp)
      else
      begin
         ctrl_errors++;
         $display("Mismatch %s: got %h expected %h", name, got, exp);
      end
   endtask

   // one table row: drive, drop the strobes, let the outputs settle, check
   task automatic apply_row(input row_t r);
      @(posedge radio_clk);
      i_set_stb    <= r.set_stb;
      i_set_addr   <= r.set_addr;
      i_set_data   <= r.set_data;
      i_rx_running <= r.rx_run;
      i_tx_running <= r.tx_run;
      i_rb_stb     <= r.rb_stb;
      i_rb_addr    <= r.rb_addr;
      @(posedge radio_clk);
      i_set_stb <= 1'b0;
      i_rb_stb  <= 1'b0;
      @(posedge radio_clk);
      @(negedge radio_clk);
      check_word("o_db_gpio_out", o_db_gpio_out, r.exp_gpio);
      check_word("o_db_gpio_ddr", o_db_gpio_ddr, r.exp_ddr);
      check_word("o_misc_out", o_misc_out, r.exp_misc);
      check_word("o_rb_data", o_rb_data, r.exp_rb);
      check_word("o_radio_led", word_t'(o_radio_led), word_t'(r.exp_led));
   endtask

   // ------------------------------
   // sample bursts with a queue model
   // ------------------------------
   task automatic run_stream(input bit rx_run, input bit tx_run);
      logic [15:0] acc;      // model of the I ramp
      logic        rs, ts;
      sample_t     rx_in, tx_in, pat;
      acc = '0;
      for (int n = 0; n < STREAM_LEN; n++)
      begin
         @(posedge radio_clk);
         rs    = (n == 0) ? 1'b1 : ((next_rand() & 32'h3) != 0);   // mostly back to back
         ts    = (n == 0) ? 1'b1 : ((next_rand() & 32'h3) != 0);
         rx_in = (n == 0) ? 32'h8000_7FFF : next_rand();  // first pair saturates
         tx_in = (n == 0) ? 32'h7FFF_8000 : next_rand();
         pat   = {acc, ~acc};
         if (rx_run)
         begin
            rx_in = {rx_in[15:0], rx_in[31:16]};   // host data must not leak through
         end
         if (rs)
         begin
            exp_rx_q.push_back(apply_offset(rx_run ? pat : rx_in, RX_OFF, 1'b1));
            exp_rx_t.push_back($time + OUT_DELAY);
         end
         if (ts)
         begin
            exp_tx_q.push_back(apply_offset(tx_run ? pat : tx_in, TX_OFF, 1'b0));
            exp_tx_t.push_back($time + OUT_DELAY);
         end
         if (rx_run && rs) acc = acc + BB_INC;     // pattern used the old value
         i_rx_running <= rx_run;
         i_tx_running <= tx_run;
         i_rx_stb     <= rs;
         i_tx_stb     <= ts;
         i_adc_rx     <= rx_in;
         i_host_tx    <= tx_in;
      end
      @(posedge radio_clk);
      i_rx_stb     <= 1'b0;
      i_tx_stb     <= 1'b0;
      i_rx_running <= 1'b0;
      i_tx_running <= 1'b0;
      while (exp_rx_q.size() != 0 || exp_tx_q.size() != 0) @(negedge radio_clk);
   endtask

   // outputs are compared away from the driving edge
   always @(negedge radio_clk)
   begin
      if (i_arst_n)
      begin
         if (o_rx_stb)
         begin
            assert (exp_rx_q.size() != 0)
            else
            begin
               sample_errors++;
               $display("Unexpected receive strobe with no sample in flight");
            end
            if (exp_rx_q.size() != 0)
            begin
               assert ($time == exp_rx_t[0])
               else
               begin
                  sample_errors++;
                  $display("Receive sample came out at %0t instead of %0t", $time, exp_rx_t[0]);
               end
               assert (o_host_rx === exp_rx_q[0])
               else
               begin
                  sample_errors++;
                  $display("Mismatch o_host_rx: got %h expected %h", o_host_rx, exp_rx_q[0]);
               end
               void'(exp_rx_q.pop_front());
               void'(exp_rx_t.pop_front());
            end
         end
         if (o_tx_stb)
         begin
            assert (exp_tx_q.size() != 0)
            else
            begin
               sample_errors++;
               $display("Unexpected transmit strobe with no sample in flight");
            end
            if (exp_tx_q.size() != 0)
            begin
               assert ($time == exp_tx_t[0])
               else
               begin
                  sample_errors++;
                  $display("Transmit sample came out at %0t instead of %0t", $time, exp_tx_t[0]);
               end
               assert (o_dac_tx === exp_tx_q[0])
               else
               begin
                  sample_errors++;
                  $display("Mismatch o_dac_tx: got %h expected %h", o_dac_tx, exp_tx_q[0]);
               end
               void'(exp_tx_q.pop_front());
               void'(exp_tx_t.pop_front());
            end
         end
      end
   end

   // guard against a hang
   always @(posedge radio_clk)
   begin
      cycles++;
      if (cycles > TIMEOUT)
      begin
         $display("Timeout after %0d cycles, samples still expected", cycles);
         $display("Simulation failed");
         $finish;
      end
   end

   // ------------------------------
   // main sequence
   // ------------------------------
   initial
   begin
      i_arst_n     = 1'b0;
      i_set_stb    = 1'b0;
      i_set_addr   = '0;
      i_set_data   = '0;
      i_rb_stb     = 1'b0;
      i_rb_addr    = '0;
      i_rx_running = 1'b0;
      i_tx_running = 1'b0;
      i_rx_stb     = 1'b0;
      i_adc_rx     = '0;
      i_tx_stb     = 1'b0;
      i_host_tx    = '0;
      i_db_gpio_in = GPIO_IN;
      i_misc_in    = MISC_IN;
      load_table();
      repeat (10) @(posedge radio_clk);
      i_arst_n <= 1'b1;
      for (int r = 0; r < NUM_ROWS; r++)
      begin
         apply_row(table_rows[r]);
      end
      run_stream(1'b0, 1'b0);   // idle, host and adc data corrected
      run_stream(1'b1, 1'b1);   // both running, pattern substituted
      run_stream(1'b1, 1'b0);   // rx pattern, host tx passes
      run_stream(1'b0, 1'b1);   // tx pattern from a ramp held at zero
      repeat (4) @(posedge radio_clk);
      $display("Errors: control %0d, samples %0d", ctrl_errors, sample_errors);
      if (ctrl_errors == 0 && sample_errors == 0)
      begin
         $display("Simulation completed successfully");
      end
      else
      begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// File: radio_core.f
radio_core_pkg.sv
settings_if.sv
sample_if.sv
db_gpio_ctrl.sv
bb_sample_source.sv
fe_correction.sv
radio_core_top.sv
tb_radio_core.sv
